// ==== common/vna_defines.svh ====
`ifndef VNA_DEFINES_SVH
`define VNA_DEFINES_SVH

// Signed ADC word
`define SAMPLE_W      16

// Magnitude after CORDIC gain
`define MAG_W         18

// Binary angle, full circle is 2**PHASE_W
`define PHASE_W       16

`define CORDIC_STAGES 14

// Block length is 2**avg_log2 points
`define AVG_LOG2_W    4
`define AVG_LOG2_MAX  8

`define ACC_W         (`MAG_W + `AVG_LOG2_MAX)

`endif

// ==== common/vna_pkg.sv ====
`include "vna_defines.svh"

package vna_pkg;

    // Input handshake
    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_ACK,
        CAP_HOLD
    } cap_state_t;

    // Output handshake
    typedef enum logic [1:0] {
        OUT_IDLE,
        OUT_REQ,
        OUT_WAIT_DROP
    } out_state_t;

    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    typedef logic [`MAG_W-1:0] mag_t;

    // Read as signed where a difference is taken
    typedef logic [`PHASE_W-1:0] phase_t;

endpackage

// ==== cordic/cordic_vectoring.sv ====
`timescale 1ns/100ps
`include "vna_defines.svh"

module cordic_vectoring (
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  vna_pkg::sample_t  in_i,
    input  vna_pkg::sample_t  in_q,
    output logic              out_valid,
    output vna_pkg::mag_t     out_mag,
    output vna_pkg::phase_t   out_phase
);
    import vna_pkg::*;

    // Two fraction bits keep the truncation error of the stages small
    localparam int FRAC = 2;
    localparam int XW   = `MAG_W + 3;
    localparam int N    = `CORDIC_STAGES;

    localparam phase_t HALF_TURN = {1'b1, {(`PHASE_W-1){1'b0}}};

    logic signed [XW-1:0]  xe;
    logic signed [XW-1:0]  ye;
    logic signed [XW-1:0]  xs [0:N];
    logic signed [XW-1:0]  ys [0:N];
    phase_t                zs [0:N];
    logic [N:0]            vld;

    // atan(2^-i) scaled to the binary-angle circle
    function automatic phase_t atan_lut(input int idx);
        case (idx)
            0:       return phase_t'(8192);
            1:       return phase_t'(4836);
            2:       return phase_t'(2555);
            3:       return phase_t'(1297);
            4:       return phase_t'(651);
            5:       return phase_t'(326);
            6:       return phase_t'(163);
            7:       return phase_t'(81);
            8:       return phase_t'(41);
            9:       return phase_t'(20);
            10:      return phase_t'(10);
            11:      return phase_t'(5);
            12:      return phase_t'(3);
            13:      return phase_t'(1);
            default: return '0;
        endcase
    endfunction

    assign xe = {{(XW-`SAMPLE_W-FRAC){in_i[`SAMPLE_W-1]}}, in_i, {FRAC{1'b0}}};
    assign ye = {{(XW-`SAMPLE_W-FRAC){in_q[`SAMPLE_W-1]}}, in_q, {FRAC{1'b0}}};

    // Left half-plane is turned by half a circle
    always_ff @(posedge aclk) begin
        if (in_i[`SAMPLE_W-1]) begin
            xs[0] <= -xe;
            ys[0] <= -ye;
            zs[0] <= HALF_TURN;
        end else begin
            xs[0] <= xe;
            ys[0] <= ye;
            zs[0] <= '0;
        end
    end

    for (genvar i = 0; i < N; i++) begin : g_stage
        always_ff @(posedge aclk) begin
            if (!ys[i][XW-1]) begin
                xs[i+1] <= xs[i] + (ys[i] >>> i);
                ys[i+1] <= ys[i] - (xs[i] >>> i);
                zs[i+1] <= zs[i] + atan_lut(i);
            end else begin
                xs[i+1] <= xs[i] - (ys[i] >>> i);
                ys[i+1] <= ys[i] + (xs[i] >>> i);
                zs[i+1] <= zs[i] - atan_lut(i);
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n)
            vld <= '0;
        else
            vld <= {vld[N-1:0], in_valid};
    end

    // x ends positive, so the integer part is the scaled magnitude
    assign out_valid = vld[N];
    assign out_mag   = xs[N][`MAG_W+FRAC-1:FRAC];
    assign out_phase = zs[N];

    // Pre-rotation and the stages must leave x in the right half-plane
    x_positive: assert property (@(posedge aclk) disable iff (!arst_n)
        out_valid |-> !xs[N][XW-1]);

endmodule

// ==== list.f ====
+incdir+common
common/vna_pkg.sv
src/pt_capture.sv
cordic/cordic_vectoring.sv
src/s11_averager.sv
src/result_handoff.sv
src/vna_s11_top.sv
test/s11_checker.sv
test/tb_vna_s11.sv

// ==== src/pt_capture.sv ====
`timescale 1ns/100ps
`include "vna_defines.svh"

module pt_capture (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic                    sample_req,
    input  vna_pkg::sample_t        fwd_i,
    input  vna_pkg::sample_t        fwd_q,
    input  vna_pkg::sample_t        rev_i,
    input  vna_pkg::sample_t        rev_q,
    input  logic [`AVG_LOG2_W-1:0]  avg_log2,
    input  logic                    block_taken,
    output logic                    sample_ack,
    output logic                    pt_valid,
    output vna_pkg::sample_t        pt_fwd_i,
    output vna_pkg::sample_t        pt_fwd_q,
    output vna_pkg::sample_t        pt_rev_i,
    output vna_pkg::sample_t        pt_rev_q,
    output logic                    pt_last,
    output logic [`AVG_LOG2_W-1:0]  pt_shift
);
    import vna_pkg::*;

    cap_state_t                state;
    logic [`AVG_LOG2_MAX-1:0]  cnt;
    logic [`AVG_LOG2_W-1:0]    shift_in;
    logic [`AVG_LOG2_W-1:0]    blk_shift;
    logic [`AVG_LOG2_MAX:0]    pts;
    logic                      last_pt;
    logic                      taken;

    // Longer blocks would overflow the accumulators
    assign shift_in  = (avg_log2 > `AVG_LOG2_MAX) ? `AVG_LOG2_W'(`AVG_LOG2_MAX) : avg_log2;
    assign blk_shift = (cnt == '0) ? shift_in : pt_shift;
    assign pts       = {{`AVG_LOG2_MAX{1'b0}}, 1'b1} << blk_shift;
    assign last_pt   = ({1'b0, cnt} == pts - 1'b1);

    always_ff @(posedge aclk) begin
        if (state == CAP_IDLE && sample_req) begin
            pt_fwd_i <= fwd_i;
            pt_fwd_q <= fwd_q;
            pt_rev_i <= rev_i;
            pt_rev_q <= rev_q;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= CAP_IDLE;
            sample_ack <= 1'b0;
            pt_valid   <= 1'b0;
            pt_last    <= 1'b0;
            pt_shift   <= '0;
            cnt        <= '0;
            taken      <= 1'b0;
        end else begin
            pt_valid <= 1'b0;
            // A slow source may still hold req when the result is taken
            if (block_taken)
                taken <= 1'b1;
            case (state)
                CAP_IDLE: begin
                    if (sample_req) begin
                        state    <= CAP_ACK;
                        pt_shift <= blk_shift;
                        pt_last  <= last_pt;
                        cnt      <= last_pt ? '0 : cnt + 1'b1;
                    end
                end
                CAP_ACK: begin
                    if (!sample_ack) begin
                        sample_ack <= 1'b1;
                        pt_valid   <= 1'b1;
                    end else if (!sample_req) begin
                        sample_ack <= 1'b0;
                        state      <= pt_last ? CAP_HOLD : CAP_IDLE;
                    end
                end
                CAP_HOLD: begin
                    if (taken) begin
                        taken <= 1'b0;
                        state <= CAP_IDLE;
                    end
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

    ack_needs_req: assert property (@(posedge aclk) disable iff (!arst_n)
        $rose(sample_ack) |-> $past(sample_req));

endmodule

// ==== src/result_handoff.sv ====
`timescale 1ns/100ps

module result_handoff (
    input  logic             aclk,
    input  logic             arst_n,
    input  logic             avg_valid,
    input  vna_pkg::mag_t    avg_fwd_mag,
    input  vna_pkg::mag_t    avg_rev_mag,
    input  vna_pkg::phase_t  avg_phase,
    input  logic             result_ack,
    output logic             result_req,
    output vna_pkg::mag_t    fwd_mag,
    output vna_pkg::mag_t    rev_mag,
    output vna_pkg::phase_t  refl_phase,
    output logic             block_taken
);
    import vna_pkg::*;

    out_state_t state;

    always_ff @(posedge aclk) begin
        if (state == OUT_IDLE && avg_valid) begin
            fwd_mag    <= avg_fwd_mag;
            rev_mag    <= avg_rev_mag;
            refl_phase <= avg_phase;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= OUT_IDLE;
            block_taken <= 1'b0;
        end else begin
            block_taken <= 1'b0;
            case (state)
                OUT_IDLE:
                    if (avg_valid)
                        state <= OUT_REQ;
                OUT_REQ:
                    if (result_ack)
                        state <= OUT_WAIT_DROP;
                OUT_WAIT_DROP:
                    if (!result_ack) begin
                        state       <= OUT_IDLE;
                        block_taken <= 1'b1;
                    end
                default: state <= OUT_IDLE;
            endcase
        end
    end

    assign result_req = (state == OUT_REQ);

    // The capture side holds the next block until this one is taken
    single_block: assert property (@(posedge aclk) disable iff (!arst_n)
        avg_valid |-> state == OUT_IDLE);

endmodule

// ==== src/s11_averager.sv ====
`timescale 1ns/100ps
`include "vna_defines.svh"

module s11_averager (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic                    fwd_valid,
    input  vna_pkg::mag_t           fwd_mag,
    input  vna_pkg::phase_t         fwd_phase,
    input  vna_pkg::mag_t           rev_mag,
    input  vna_pkg::phase_t         rev_phase,
    input  logic                    pt_last,
    input  logic [`AVG_LOG2_W-1:0]  pt_shift,
    output logic                    avg_valid,
    output vna_pkg::mag_t           avg_fwd_mag,
    output vna_pkg::mag_t           avg_rev_mag,
    output vna_pkg::phase_t         avg_phase
);
    import vna_pkg::*;

    localparam int N = `CORDIC_STAGES;

    logic [N:0]                last_dly;
    logic [`AVG_LOG2_W-1:0]    shift_dly [0:N];
    logic [`ACC_W-1:0]         acc_fwd;
    logic [`ACC_W-1:0]         acc_rev;
    logic signed [`ACC_W-1:0]  acc_ph;
    phase_t                    refl;
    logic [`ACC_W:0]           sum_fwd;
    logic [`ACC_W:0]           sum_rev;
    logic signed [`ACC_W:0]    sum_ph;
    logic [`ACC_W:0]           mean_fwd;
    logic [`ACC_W:0]           mean_rev;
    logic signed [`ACC_W:0]    mean_ph;

    // Block markers ride alongside the CORDIC pipeline
    always_ff @(posedge aclk) begin
        last_dly     <= {last_dly[N-1:0], pt_last};
        shift_dly[0] <= pt_shift;
        for (int k = 1; k <= N; k++)
            shift_dly[k] <= shift_dly[k-1];
    end

    // Wraps on the circle, so +170 to -170 gives a small positive step
    assign refl = rev_phase - fwd_phase;

    assign sum_fwd = {1'b0, acc_fwd} + {{(`ACC_W+1-`MAG_W){1'b0}}, fwd_mag};
    assign sum_rev = {1'b0, acc_rev} + {{(`ACC_W+1-`MAG_W){1'b0}}, rev_mag};
    assign sum_ph  = {acc_ph[`ACC_W-1], acc_ph}
                   + {{(`ACC_W+1-`PHASE_W){refl[`PHASE_W-1]}}, refl};

    assign mean_fwd = sum_fwd >> shift_dly[N];
    assign mean_rev = sum_rev >> shift_dly[N];
    assign mean_ph  = sum_ph >>> shift_dly[N];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            avg_valid <= 1'b0;
            acc_fwd   <= '0;
            acc_rev   <= '0;
            acc_ph    <= '0;
        end else begin
            avg_valid <= 1'b0;
            if (fwd_valid) begin
                if (last_dly[N]) begin
                    avg_valid <= 1'b1;
                    acc_fwd   <= '0;
                    acc_rev   <= '0;
                    acc_ph    <= '0;
                end else begin
                    acc_fwd <= sum_fwd[`ACC_W-1:0];
                    acc_rev <= sum_rev[`ACC_W-1:0];
                    acc_ph  <= sum_ph[`ACC_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (fwd_valid && last_dly[N]) begin
            avg_fwd_mag <= mean_fwd[`MAG_W-1:0];
            avg_rev_mag <= mean_rev[`MAG_W-1:0];
            avg_phase   <= mean_ph[`PHASE_W-1:0];
        end
    end

    // Holds as long as the block never exceeds 2**AVG_LOG2_MAX points
    acc_no_overflow: assert property (@(posedge aclk) disable iff (!arst_n)
        fwd_valid |-> !sum_fwd[`ACC_W] && !sum_rev[`ACC_W]
                      && (sum_ph[`ACC_W] == sum_ph[`ACC_W-1]));

endmodule

// ==== src/vna_s11_top.sv ====
`timescale 1ns/100ps
`include "vna_defines.svh"

module vna_s11_top (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic [`AVG_LOG2_W-1:0]  avg_log2,
    input  logic                    sample_req,
    input  vna_pkg::sample_t        fwd_i,
    input  vna_pkg::sample_t        fwd_q,
    input  vna_pkg::sample_t        rev_i,
    input  vna_pkg::sample_t        rev_q,
    input  logic                    result_ack,
    output logic                    sample_ack,
    output logic                    result_req,
    output vna_pkg::mag_t           fwd_mag,
    output vna_pkg::mag_t           rev_mag,
    output vna_pkg::phase_t         refl_phase
);
    import vna_pkg::*;

    logic                    pt_valid;
    sample_t                 pt_fwd_i;
    sample_t                 pt_fwd_q;
    sample_t                 pt_rev_i;
    sample_t                 pt_rev_q;
    logic                    pt_last;
    logic [`AVG_LOG2_W-1:0]  pt_shift;
    logic                    block_taken;
    logic                    c_fwd_valid;
    mag_t                    c_fwd_mag;
    phase_t                  c_fwd_phase;
    mag_t                    c_rev_mag;
    phase_t                  c_rev_phase;
    logic                    avg_valid;
    mag_t                    avg_fwd_mag;
    mag_t                    avg_rev_mag;
    phase_t                  avg_phase;

    pt_capture pt_capture_inst (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .sample_req  (sample_req),
        .fwd_i       (fwd_i),
        .fwd_q       (fwd_q),
        .rev_i       (rev_i),
        .rev_q       (rev_q),
        .avg_log2    (avg_log2),
        .block_taken (block_taken),
        .sample_ack  (sample_ack),
        .pt_valid    (pt_valid),
        .pt_fwd_i    (pt_fwd_i),
        .pt_fwd_q    (pt_fwd_q),
        .pt_rev_i    (pt_rev_i),
        .pt_rev_q    (pt_rev_q),
        .pt_last     (pt_last),
        .pt_shift    (pt_shift)
    );

    cordic_vectoring cordic_fwd (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .in_valid  (pt_valid),
        .in_i      (pt_fwd_i),
        .in_q      (pt_fwd_q),
        .out_valid (c_fwd_valid),
        .out_mag   (c_fwd_mag),
        .out_phase (c_fwd_phase)
    );

    // Same latency as the forward chain, its valid is not needed
    cordic_vectoring cordic_rev (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .in_valid  (pt_valid),
        .in_i      (pt_rev_i),
        .in_q      (pt_rev_q),
        .out_valid (),
        .out_mag   (c_rev_mag),
        .out_phase (c_rev_phase)
    );

    s11_averager s11_averager_inst (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .fwd_valid   (c_fwd_valid),
        .fwd_mag     (c_fwd_mag),
        .fwd_phase   (c_fwd_phase),
        .rev_mag     (c_rev_mag),
        .rev_phase   (c_rev_phase),
        .pt_last     (pt_last),
        .pt_shift    (pt_shift),
        .avg_valid   (avg_valid),
        .avg_fwd_mag (avg_fwd_mag),
        .avg_rev_mag (avg_rev_mag),
        .avg_phase   (avg_phase)
    );

    result_handoff result_handoff_inst (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .avg_valid   (avg_valid),
        .avg_fwd_mag (avg_fwd_mag),
        .avg_rev_mag (avg_rev_mag),
        .avg_phase   (avg_phase),
        .result_ack  (result_ack),
        .result_req  (result_req),
        .fwd_mag     (fwd_mag),
        .rev_mag     (rev_mag),
        .refl_phase  (refl_phase),
        .block_taken (block_taken)
    );

endmodule

// ==== test/s11_checker.sv ====
`timescale 1ns/100ps
`include "vna_defines.svh"

module s11_checker #(
    parameter int NAME_W  = 128,
    parameter int MAX_BLK = 32
) (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic                    sample_ack,
    input  vna_pkg::sample_t        fwd_i,
    input  vna_pkg::sample_t        fwd_q,
    input  vna_pkg::sample_t        rev_i,
    input  vna_pkg::sample_t        rev_q,
    input  logic [`AVG_LOG2_W-1:0]  avg_log2,
    input  logic [NAME_W-1:0]       test_name,
    input  logic                    result_req,
    input  logic                    result_ack,
    input  vna_pkg::mag_t           fwd_mag,
    input  vna_pkg::mag_t           rev_mag,
    input  vna_pkg::phase_t         refl_phase,
    output logic [31:0]             error_count,
    output logic [31:0]             test_count,
    output logic [31:0]             pass_count,
    output logic [31:0]             blocks_sent,
    output logic [31:0]             results_seen
);
    import vna_pkg::*;

    localparam real MAG_TOL   = 4.0;
    localparam real PHASE_TOL = 8.0;
    localparam real CIRCLE    = 2.0 ** `PHASE_W;
    localparam real PI        = 3.14159265358979;

    real                gain;
    real                sum_fwd;
    real                sum_rev;
    real                sum_ph;
    int                 pts_in_blk;
    int                 blk_len;
    int                 pending;
    bit                 cur_bad;
    logic [NAME_W-1:0]  blk_name;
    logic               rst_d;
    logic               ack_d;
    logic               req_d;
    logic               rack_d;
    real                exp_fwd [0:MAX_BLK-1];
    real                exp_rev [0:MAX_BLK-1];
    real                exp_ph [0:MAX_BLK-1];
    bit                 exp_bad [0:MAX_BLK-1];
    logic [NAME_W-1:0]  exp_name [0:MAX_BLK-1];
    int                 wr_idx;
    int                 rd_idx;

    // Product of the per-stage growth sqrt(1 + 2^-2i)
    function automatic real cordic_gain(input int stages);
        real k;
        k = 1.0;
        for (int i = 0; i < stages; i++)
            k = k * $sqrt(1.0 + 2.0 ** (-2.0 * i));
        return k;
    endfunction

    function automatic real wrap_angle(input real a);
        real w;
        w = a;
        while (w >= CIRCLE / 2.0)
            w = w - CIRCLE;
        while (w < -CIRCLE / 2.0)
            w = w + CIRCLE;
        return w;
    endfunction

    function automatic real binary_angle(input real i, input real q);
        return $atan2(q, i) * CIRCLE / (2.0 * PI);
    endfunction

    function automatic real abs_real(input real a);
        return (a < 0.0) ? -a : a;
    endfunction

    task automatic report_mismatch(input string sig, input real expv, input int actv);
        $display("[FAIL] t=%0t %0s %0s: expected %0.1f, got %0d",
                 $time, exp_name[rd_idx], sig, expv, actv);
        error_count = error_count + 1;
    endtask

    task automatic take_point();
        int  lg;
        real pf;
        real pr;
        if (pending > 0) begin
            $display("t=%0t sample_ack answered a new point while a finished block was waiting",
                     $time);
            error_count = error_count + 1;
            cur_bad = 1'b1;
        end
        if (pts_in_blk == 0) begin
            lg       = (avg_log2 > `AVG_LOG2_MAX) ? `AVG_LOG2_MAX : avg_log2;
            blk_len  = 1 << lg;
            blk_name = test_name;
            sum_fwd  = 0.0;
            sum_rev  = 0.0;
            sum_ph   = 0.0;
        end
        pf      = binary_angle(fwd_i, fwd_q);
        pr      = binary_angle(rev_i, rev_q);
        sum_fwd = sum_fwd + gain * $sqrt(1.0 * fwd_i * fwd_i + 1.0 * fwd_q * fwd_q);
        sum_rev = sum_rev + gain * $sqrt(1.0 * rev_i * rev_i + 1.0 * rev_q * rev_q);
        sum_ph  = sum_ph + wrap_angle(pr - pf);
        pts_in_blk++;
        if (pts_in_blk == blk_len) begin
            if (wr_idx < MAX_BLK) begin
                exp_fwd[wr_idx]  = sum_fwd / blk_len;
                exp_rev[wr_idx]  = sum_rev / blk_len;
                exp_ph[wr_idx]   = sum_ph / blk_len;
                exp_bad[wr_idx]  = cur_bad;
                exp_name[wr_idx] = blk_name;
                wr_idx++;
            end else begin
                $display("t=%0t more blocks than the checker can track", $time);
                error_count = error_count + 1;
            end
            pts_in_blk  = 0;
            cur_bad     = 1'b0;
            pending++;
            blocks_sent = blocks_sent + 1;
        end
    endtask

    task automatic check_result();
        int  act;
        int  bad;
        bad = 0;
        if (rd_idx == wr_idx) begin
            $display("t=%0t result_req rose with no finished block outstanding", $time);
            error_count = error_count + 1;
        end else begin
            act = fwd_mag;
            if (abs_real(act - exp_fwd[rd_idx]) > MAG_TOL) begin
                report_mismatch("fwd_mag", exp_fwd[rd_idx], act);
                bad++;
            end
            act = rev_mag;
            if (abs_real(act - exp_rev[rd_idx]) > MAG_TOL) begin
                report_mismatch("rev_mag", exp_rev[rd_idx], act);
                bad++;
            end
            act = $signed(refl_phase);
            // Distance on the circle, so -32768 and +32767 are neighbours
            if (abs_real(wrap_angle(act - exp_ph[rd_idx])) > PHASE_TOL) begin
                report_mismatch("refl_phase", exp_ph[rd_idx], act);
                bad++;
            end
            test_count   = test_count + 1;
            results_seen = results_seen + 1;
            if (bad == 0 && !exp_bad[rd_idx]) begin
                pass_count = pass_count + 1;
                $display("PASS  %0s  fwd_mag=%0d rev_mag=%0d refl_phase=%0d",
                         exp_name[rd_idx], fwd_mag, rev_mag, $signed(refl_phase));
            end else begin
                $display("FAIL  %0s", exp_name[rd_idx]);
            end
            rd_idx++;
        end
    endtask

    task automatic check_reset_state();
        test_count = test_count + 1;
        if (sample_ack !== 1'b0 || result_req !== 1'b0) begin
            $display("t=%0t handshake outputs not low after reset (sample_ack=%b result_req=%b)",
                     $time, sample_ack, result_req);
            error_count = error_count + 1;
            $display("FAIL  reset");
        end else begin
            pass_count = pass_count + 1;
            $display("PASS  reset  sample_ack and result_req low");
        end
    endtask

    initial begin
        gain         = cordic_gain(`CORDIC_STAGES);
        error_count  = 0;
        test_count   = 0;
        pass_count   = 0;
        blocks_sent  = 0;
        results_seen = 0;
        pts_in_blk   = 0;
        blk_len      = 1;
        pending      = 0;
        cur_bad      = 1'b0;
        wr_idx       = 0;
        rd_idx       = 0;
        rst_d        = 1'b0;
        ack_d        = 1'b0;
        req_d        = 1'b0;
        rack_d       = 1'b0;
    end

    // Inputs change on the falling edge, so the rising edge sees settled values
    always @(posedge aclk) begin
        rst_d  <= arst_n;
        ack_d  <= sample_ack;
        req_d  <= result_req;
        rack_d <= result_ack;
        if (arst_n && !rst_d)
            check_reset_state();
        if (arst_n && rst_d) begin
            if (sample_ack && !ack_d)
                take_point();
            if (result_req && !req_d)
                check_result();
            // Result handshake complete, capture may accept the next block
            if (!result_ack && rack_d)
                pending--;
        end
    end

endmodule

// ==== test/tb_vna_s11.sv ====
`timescale 1ns/100ps
`include "vna_defines.svh"

module tb_vna_s11;
    import vna_pkg::*;

    localparam int NAME_W   = 128;
    localparam int MAX_ROWS = 48;
    localparam int MAX_BLK  = 32;

    logic                    aclk;
    logic                    arst_n;
    logic [`AVG_LOG2_W-1:0]  avg_log2;
    logic                    sample_req;
    sample_t                 fwd_i;
    sample_t                 fwd_q;
    sample_t                 rev_i;
    sample_t                 rev_q;
    logic                    result_ack;
    logic                    sample_ack;
    logic                    result_req;
    mag_t                    fwd_mag;
    mag_t                    rev_mag;
    phase_t                  refl_phase;
    logic [NAME_W-1:0]       cur_name;
    logic [31:0]             error_count;
    logic [31:0]             test_count;
    logic [31:0]             pass_count;
    logic [31:0]             blocks_sent;
    logic [31:0]             results_seen;

    // Stimulus table, one row per point
    sample_t                 row_fi [0:MAX_ROWS-1];
    sample_t                 row_fq [0:MAX_ROWS-1];
    sample_t                 row_ri [0:MAX_ROWS-1];
    sample_t                 row_rq [0:MAX_ROWS-1];
    logic [`AVG_LOG2_W-1:0]  row_lg [0:MAX_ROWS-1];
    int                      row_dly [0:MAX_ROWS-1];
    logic [NAME_W-1:0]       row_name [0:MAX_ROWS-1];
    int                      blk_dly [0:MAX_BLK-1];
    int                      n_rows;
    int                      n_blocks;
    int                      blk_fill;
    int                      cycles;
    int                      cycle_limit;
    int                      tb_errors;
    int                      seed_val;

    vna_s11_top vna_s11_top_inst (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .avg_log2   (avg_log2),
        .sample_req (sample_req),
        .fwd_i      (fwd_i),
        .fwd_q      (fwd_q),
        .rev_i      (rev_i),
        .rev_q      (rev_q),
        .result_ack (result_ack),
        .sample_ack (sample_ack),
        .result_req (result_req),
        .fwd_mag    (fwd_mag),
        .rev_mag    (rev_mag),
        .refl_phase (refl_phase)
    );

    s11_checker #(.NAME_W(NAME_W), .MAX_BLK(MAX_BLK)) s11_checker_inst (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .sample_ack   (sample_ack),
        .fwd_i        (fwd_i),
        .fwd_q        (fwd_q),
        .rev_i        (rev_i),
        .rev_q        (rev_q),
        .avg_log2     (avg_log2),
        .test_name    (cur_name),
        .result_req   (result_req),
        .result_ack   (result_ack),
        .fwd_mag      (fwd_mag),
        .rev_mag      (rev_mag),
        .refl_phase   (refl_phase),
        .error_count  (error_count),
        .test_count   (test_count),
        .pass_count   (pass_count),
        .blocks_sent  (blocks_sent),
        .results_seen (results_seen)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // Sink delay for a block is taken from the row that closes it
    task automatic add_point(input int fi, input int fq, input int ri, input int rq,
                             input int lg, input int dly, input logic [NAME_W-1:0] name);
        row_fi[n_rows]   = fi;
        row_fq[n_rows]   = fq;
        row_ri[n_rows]   = ri;
        row_rq[n_rows]   = rq;
        row_lg[n_rows]   = lg;
        row_dly[n_rows]  = dly;
        row_name[n_rows] = name;
        n_rows++;
        blk_fill++;
        if (blk_fill == (1 << lg)) begin
            blk_dly[n_blocks] = dly + ($urandom % 4);
            n_blocks++;
            blk_fill = 0;
        end
    endtask

    task automatic build_table();
        add_point(20000, 0, 0, 20000, 0, 2, "axis_0");
        add_point(0, 20000, -20000, 0, 0, 0, "axis_90");
        add_point(-20000, 0, 0, -20000, 0, 1, "axis_180");
        add_point(14142, 14142, 14142, -14142, 0, 3, "diag_45");
        add_point(-14142, 14142, 10000, 10000, 0, 0, "diag_135");
        // Forward near +170 and reverse near -170 degrees
        add_point(-19696, 3473, -19696, -3473, 0, 2, "wrap_single");
        add_point(-19696, 3473, -19696, -3473, 1, 1, "wrap_pair");
        add_point(-19924, 1743, -19924, -1743, 1, 1, "wrap_pair");
        add_point(15000, 5000, 3000, 7000, 2, 4, "avg_4");
        add_point(12000, 9000, -2000, 6000, 2, 4, "avg_4");
        add_point(16000, -2000, 5000, -1000, 2, 4, "avg_4");
        add_point(10000, 10000, 1000, 8000, 2, 4, "avg_4");
        for (int k = 0; k < 16; k++)
            add_point(20000 - 500 * k, 3000 + 700 * k, -4000 + 300 * k, 9000 - 200 * k,
                      4, 5, "avg_16");
        // Long sink delay so the next block runs into the hold
        add_point(18000, 6000, 7000, 2000, 1, 80, "hold_a");
        add_point(17000, 8000, 6000, 4000, 1, 80, "hold_a");
        add_point(-9000, 15000, 12000, -3000, 1, 90, "hold_b");
        add_point(-7000, 16000, 11000, -5000, 1, 90, "hold_b");
    endtask

    task automatic send_rows();
        for (int r = 0; r < n_rows; r++) begin
            @(negedge aclk);
            fwd_i      = row_fi[r];
            fwd_q      = row_fq[r];
            rev_i      = row_ri[r];
            rev_q      = row_rq[r];
            avg_log2   = row_lg[r];
            cur_name   = row_name[r];
            sample_req = 1'b1;
            @(negedge aclk);
            while (!sample_ack)
                @(negedge aclk);
            sample_req = 1'b0;
            @(negedge aclk);
            while (sample_ack)
                @(negedge aclk);
        end
    endtask

    task automatic answer_results();
        for (int b = 0; b < n_blocks; b++) begin
            @(negedge aclk);
            while (!result_req)
                @(negedge aclk);
            repeat (blk_dly[b]) @(negedge aclk);
            result_ack = 1'b1;
            @(negedge aclk);
            while (result_req)
                @(negedge aclk);
            result_ack = 1'b0;
        end
    endtask

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, a handshake with the DUT never completed",
                     cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        seed_val    = $urandom(25612);
        cycles      = 0;
        cycle_limit = 0;
        tb_errors   = 0;
        n_rows      = 0;
        n_blocks    = 0;
        blk_fill    = 0;
        arst_n      = 1'b0;
        sample_req  = 1'b0;
        result_ack  = 1'b0;
        avg_log2    = '0;
        fwd_i       = '0;
        fwd_q       = '0;
        rev_i       = '0;
        rev_q       = '0;
        cur_name    = '0;
        build_table();
        cycle_limit = n_rows * ((1 << `AVG_LOG2_MAX) * 4 + 60);
        repeat (5) @(negedge aclk);
        arst_n = 1'b1;
        // Idle time in which no result may show up
        repeat (10) @(negedge aclk);
        fork
            answer_results();
        join_none
        send_rows();
        while (results_seen < n_blocks)
            @(negedge aclk);
        repeat (40) @(negedge aclk);
        if (blocks_sent != n_blocks || results_seen != n_blocks) begin
            $display("block count wrong: %0d in table, %0d sent, %0d results",
                     n_blocks, blocks_sent, results_seen);
            tb_errors++;
        end
        $display("tests: %0d  passed: %0d  failed: %0d  errors: %0d",
                 test_count, pass_count, test_count - pass_count, error_count + tb_errors);
        if (error_count == 0 && tb_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
